/* verilog/mem_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory stage shared definitions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package mem_pkg;

    // Datapath sizes
    localparam int unsigned WORD_W      = 32;               // Data and address width
    localparam int unsigned DMEM_WORDS  = 256;              // Data RAM depth in words
    localparam int unsigned DMEM_IDX_W  = $clog2(DMEM_WORDS); // Word index, addr[9:2]
    localparam int unsigned OFFSET_W    = 2;                // Byte offset, addr[1:0]

    // Result queue and credit sizes
    localparam int unsigned QUEUE_DEPTH = 4;                // Entries and initial credits
    localparam int unsigned QPTR_W      = $clog2(QUEUE_DEPTH);
    localparam int unsigned QCNT_W      = $clog2(QUEUE_DEPTH + 1);
    localparam logic [QCNT_W-1:0] CREDIT_INIT = QCNT_W'(QUEUE_DEPTH);

    // Fault status
    localparam int unsigned FAULT_CNT_W = 8;                // Saturating misalign counter

    // Memory operation from the execute stage
    typedef enum logic [3:0] {
        NOP,                                                // Pass ex_out through
        LW,
        LH,
        LHU,
        LB,
        LBU,
        SW,
        SH,
        SB
    } mem_op_e;

    // Request from execute
    typedef struct packed {
        logic              en;                              // Request valid
        mem_op_e           op;
        logic [WORD_W-1:0] ex_out;                          // Address or pass-through value
        logic [WORD_W-1:0] wr_data;                         // Store data
    } mem_req_t;

    // Result to write-back
    typedef struct packed {
        logic [WORD_W-1:0] data;                            // Load, pass-through or zero
        logic              miss_align;
        logic              is_store;                        // Store actually written
    } mem_result_t;

endpackage

/* verilog/dmem.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word-addressed data RAM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module dmem (
    input  logic                           clk,
    input  logic                           we,          // Whole word write
    input  logic [mem_pkg::DMEM_IDX_W-1:0] word_addr,
    input  logic [mem_pkg::WORD_W-1:0]     wr_word,
    output logic [mem_pkg::WORD_W-1:0]     rd_word      // Combinational read
);

    logic [mem_pkg::WORD_W-1:0] mem_array [mem_pkg::DMEM_WORDS];

    // Power-up contents are all zero
    initial begin
        for (int i = 0; i < mem_pkg::DMEM_WORDS; i++) begin
            mem_array[i] = '0;
        end
    end

    assign rd_word = mem_array[word_addr];              // Old word for loads and merges

    always_ff @(posedge clk) begin
        if (we) begin
            mem_array[word_addr] <= wr_word;
        end
    end

endmodule

/* verilog/mem_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory access control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module mem_ctrl (
    input  mem_pkg::mem_req_t              req,
    input  logic [mem_pkg::WORD_W-1:0]     rd_word,     // Old word from the RAM
    input  logic                           store_block, // Sticky fault holds off stores
    output logic                           we,
    output logic [mem_pkg::DMEM_IDX_W-1:0] word_addr,
    output logic [mem_pkg::WORD_W-1:0]     wr_word,     // Merged store word
    output mem_pkg::mem_result_t           result
);

    logic [mem_pkg::OFFSET_W-1:0] offset;
    logic [15:0]                  sel_half;
    logic [7:0]                   sel_byte;

    assign offset    = req.ex_out[mem_pkg::OFFSET_W-1:0];
    assign word_addr = req.ex_out[mem_pkg::DMEM_IDX_W+mem_pkg::OFFSET_W-1:mem_pkg::OFFSET_W];

    // Lane selection for sub-word loads
    assign sel_half = offset[1] ? rd_word[31:16] : rd_word[15:0];
    assign sel_byte = rd_word[{offset, 3'b000} +: 8];

    always_comb begin
        we      = 1'b0;
        wr_word = req.wr_data;
        result  = '0;
        if (req.en) begin
            case (req.op)
                mem_pkg::LW: begin
                    if (offset == '0) begin
                        result.data = rd_word;
                    end else begin
                        result.miss_align = 1'b1;
                    end
                end
                mem_pkg::LH: begin
                    if (!offset[0]) begin
                        result.data = {{16{sel_half[15]}}, sel_half};   // Sign extend
                    end else begin
                        result.miss_align = 1'b1;
                    end
                end
                mem_pkg::LHU: begin
                    if (!offset[0]) begin
                        result.data = {16'h0000, sel_half};
                    end else begin
                        result.miss_align = 1'b1;
                    end
                end
                mem_pkg::LB: begin
                    result.data = {{24{sel_byte[7]}}, sel_byte};        // Any offset
                end
                mem_pkg::LBU: begin
                    result.data = {24'h000000, sel_byte};
                end
                mem_pkg::SW: begin
                    if (offset == '0) begin
                        we = !store_block;
                    end else begin
                        result.miss_align = 1'b1;
                    end
                end
                mem_pkg::SH: begin
                    if (!offset[0]) begin
                        if (offset[1]) begin
                            wr_word = {req.wr_data[15:0], rd_word[15:0]};
                        end else begin
                            wr_word = {rd_word[31:16], req.wr_data[15:0]};
                        end
                        we = !store_block;
                    end else begin
                        result.miss_align = 1'b1;
                    end
                end
                mem_pkg::SB: begin
                    // Byte merge into the old word
                    case (offset)
                        2'd0:    wr_word = {rd_word[31:8], req.wr_data[7:0]};
                        2'd1:    wr_word = {rd_word[31:16], req.wr_data[7:0], rd_word[7:0]};
                        2'd2:    wr_word = {rd_word[31:24], req.wr_data[7:0], rd_word[15:0]};
                        default: wr_word = {req.wr_data[7:0], rd_word[23:0]};
                    endcase
                    we = !store_block;
                end
                default: begin
                    result.data = req.ex_out;                   // Non-memory op
                end
            endcase
        end
        result.is_store = we;
    end

endmodule

/* verilog/mem_fault_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Misalign fault status
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module mem_fault_regs (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            fault,          // Misaligned request this cycle
    input  logic [mem_pkg::WORD_W-1:0]      fault_addr_in,
    input  logic                            fault_clear,
    output logic                            store_block,    // Sticky flag
    output logic [mem_pkg::FAULT_CNT_W-1:0] fault_count,
    output logic [mem_pkg::WORD_W-1:0]      fault_addr
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fault_count <= '0;
            fault_addr  <= '0;
            store_block <= 1'b0;
        end else begin
            if (fault) begin
                if (fault_count != '1) begin
                    fault_count <= fault_count + 1'b1;      // Saturates at all ones
                end
                fault_addr  <= fault_addr_in;               // Latest faulting address
                store_block <= 1'b1;                        // Wins over a clear
            end else if (fault_clear) begin
                store_block <= 1'b0;
            end
        end
    end

endmodule

/* verilog/mem_out_queue.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Result queue with credit flow control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module mem_out_queue (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 push,
    input  mem_pkg::mem_result_t push_data,
    input  logic                 res_credit,    // Credit back from write-back
    output logic                 res_valid,
    output mem_pkg::mem_result_t res,
    output logic                 req_credit     // Credit back to execute
);

    mem_pkg::mem_result_t        buffer [mem_pkg::QUEUE_DEPTH];
    logic [mem_pkg::QPTR_W-1:0]  wr_ptr;
    logic [mem_pkg::QPTR_W-1:0]  rd_ptr;
    logic [mem_pkg::QCNT_W-1:0]  count;         // Occupancy
    logic [mem_pkg::QCNT_W-1:0]  out_credits;   // Credits held toward write-back
    logic                        send;

    // Head leaves when there is an entry and a credit to spend
    assign send       = (count != '0) && (out_credits != '0);
    assign res_valid  = send;
    assign res        = buffer[rd_ptr];
    assign req_credit = send;

    always_ff @(posedge clk) begin
        if (push) begin
            buffer[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            out_credits <= mem_pkg::CREDIT_INIT;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == mem_pkg::QPTR_W'(mem_pkg::QUEUE_DEPTH - 1)) ?
                          '0 : wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= (rd_ptr == mem_pkg::QPTR_W'(mem_pkg::QUEUE_DEPTH - 1)) ?
                          '0 : rd_ptr + 1'b1;
            end
            case ({push, send})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;            // Idle or push and pop together
            endcase
            case ({send, res_credit})
                2'b10:   out_credits <= out_credits - 1'b1;
                2'b01:   out_credits <= out_credits + 1'b1;
                default: out_credits <= out_credits;
            endcase
        end
    end

endmodule

/* verilog/mem_stage.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory access stage top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module mem_stage (
    input  logic                            clk,
    input  logic                            rst_n,
    input  mem_pkg::mem_req_t               req,
    output logic                            req_credit,
    output logic                            res_valid,
    output mem_pkg::mem_result_t            res,
    input  logic                            res_credit,
    input  logic                            fault_clear,
    output logic [mem_pkg::FAULT_CNT_W-1:0] fault_count,
    output logic [mem_pkg::WORD_W-1:0]      fault_addr,
    output logic                            fault_sticky
);

    logic [mem_pkg::WORD_W-1:0]     rd_word;
    logic                           we;
    logic [mem_pkg::DMEM_IDX_W-1:0] word_addr;
    logic [mem_pkg::WORD_W-1:0]     wr_word;
    mem_pkg::mem_result_t           result;
    logic                           fault;

    assign fault = result.miss_align & req.en;

    mem_ctrl u_mem_ctrl (
        .req         (req),
        .rd_word     (rd_word),
        .store_block (fault_sticky),    // Stores held off while flag is set
        .we          (we),
        .word_addr   (word_addr),
        .wr_word     (wr_word),
        .result      (result)
    );

    dmem u_dmem (
        .clk       (clk),
        .we        (we),
        .word_addr (word_addr),
        .wr_word   (wr_word),
        .rd_word   (rd_word)
    );

    mem_fault_regs u_mem_fault_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .fault         (fault),
        .fault_addr_in (req.ex_out),
        .fault_clear   (fault_clear),
        .store_block   (fault_sticky),
        .fault_count   (fault_count),
        .fault_addr    (fault_addr)
    );

    mem_out_queue u_mem_out_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (req.en),           // Every request yields one result
        .push_data  (result),
        .res_credit (res_credit),
        .res_valid  (res_valid),
        .res        (res),
        .req_credit (req_credit)
    );

endmodule

/* bench/mem_ref.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory stage reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

logic [mem_pkg::WORD_W-1:0]      model_mem [mem_pkg::DMEM_WORDS];
logic                            model_sticky = 1'b0;
logic [mem_pkg::FAULT_CNT_W-1:0] model_count  = '0;
logic [mem_pkg::WORD_W-1:0]      model_addr   = '0;

// Expected result of one request, then model memory and fault state advance
function automatic mem_pkg::mem_result_t model_request(input mem_pkg::mem_req_t r,
                                                       input logic clear);
    mem_pkg::mem_result_t           e;
    logic [mem_pkg::DMEM_IDX_W-1:0] idx;
    logic [mem_pkg::WORD_W-1:0]     w;
    logic [mem_pkg::WORD_W-1:0]     lane;
    int                             sh;
    e    = '0;
    idx  = r.ex_out[mem_pkg::DMEM_IDX_W+1:2];
    w    = model_mem[idx];
    sh   = 8 * int'(r.ex_out[1:0]);                 // Bit position of the byte offset
    lane = w >> sh;
    case (r.op)
        mem_pkg::LW, mem_pkg::SW:               e.miss_align = (sh != 0);
        mem_pkg::LH, mem_pkg::LHU, mem_pkg::SH: e.miss_align = r.ex_out[0];
        default:                                e.miss_align = 1'b0;
    endcase
    if (!e.miss_align) begin
        case (r.op)
            mem_pkg::LW:  e.data = w;
            mem_pkg::LH:  e.data = 32'($signed(lane[15:0]));
            mem_pkg::LHU: e.data = 32'(lane[15:0]);
            mem_pkg::LB:  e.data = 32'($signed(lane[7:0]));
            mem_pkg::LBU: e.data = 32'(lane[7:0]);
            mem_pkg::SW:  w = r.wr_data;
            mem_pkg::SH:  w[sh +: 16] = r.wr_data[15:0];
            mem_pkg::SB:  w[sh +: 8] = r.wr_data[7:0];
            default:      e.data = r.ex_out;        // Pass-through
        endcase
    end
    e.is_store = !e.miss_align && !model_sticky && (r.op inside {mem_pkg::SW, mem_pkg::SH,
                                                                 mem_pkg::SB});
    if (e.is_store) begin
        model_mem[idx] = w;
    end
    if (e.miss_align) begin
        if (model_count != '1) begin
            model_count++;
        end
        model_addr   = r.ex_out;
        model_sticky = 1'b1;                        // A fault beats a clear
    end else if (clear) begin
        model_sticky = 1'b0;
    end
    return e;
endfunction

/* bench/tb_mem_stage.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory stage testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module tb_mem_stage;

    localparam int NUM_RANDOM = 400;
    localparam int NUM_REQS   = NUM_RANDOM + 200;   // Bound on all requests

    logic                            clk = 1'b0;
    logic                            rst_n;
    logic                            req_credit;
    logic                            res_valid;
    logic                            res_credit;
    logic                            fault_clear;
    logic                            fault_sticky;
    logic [mem_pkg::FAULT_CNT_W-1:0] fault_count;
    logic [mem_pkg::WORD_W-1:0]      fault_addr;
    mem_pkg::mem_req_t               req;
    mem_pkg::mem_result_t            res;
    mem_pkg::mem_result_t            exp_q [$];     // Expected results in issue order
    int   seed            = 48;
    int   errors          = 0;
    int   req_credits     = mem_pkg::QUEUE_DEPTH;   // Held by the execute side
    int   wb_credits      = mem_pkg::QUEUE_DEPTH;   // Still spendable by the DUT
    int   pending_returns = 0;
    logic withhold        = 1'b0;
    logic random_hold     = 1'b0;

    `include "mem_ref.svh"

    mem_stage uut (.*);

    always #10 clk = ~clk;

    task automatic check_result(input mem_pkg::mem_result_t got,
                                input mem_pkg::mem_result_t expected);
        if (got !== expected) begin
            errors++;
            $display("Error: res got data %h miss_align %h is_store %h, expected %h %h %h",
                     got.data, got.miss_align, got.is_store,
                     expected.data, expected.miss_align, expected.is_store);
        end
    endtask

    task automatic check_fault(input logic [mem_pkg::FAULT_CNT_W-1:0] count,
                               input logic [mem_pkg::WORD_W-1:0] addr, input logic sticky);
        if (count !== model_count) begin
            errors++;
            $display("Error: fault_count got %h expected %h", count, model_count);
        end
        if (addr !== model_addr) begin
            errors++;
            $display("Error: fault_addr got %h expected %h", addr, model_addr);
        end
        if (sticky !== model_sticky) begin
            errors++;
            $display("Error: fault_sticky got %h expected %h", sticky, model_sticky);
        end
    endtask

    task automatic send_req(input mem_pkg::mem_op_e op, input logic [mem_pkg::WORD_W-1:0] addr,
                            input logic [mem_pkg::WORD_W-1:0] wdata, input logic clear);
        mem_pkg::mem_req_t r;
        r.en      = 1'b1;
        r.op      = op;
        r.ex_out  = addr;
        r.wr_data = wdata;
        @(posedge clk);
        #2;
        while (req_credits == 0) begin              // Idle until a credit comes back
            req         = '0;
            fault_clear = 1'b0;
            @(posedge clk);
            #2;
        end
        req         = r;
        fault_clear = clear;
        req_credits--;
        exp_q.push_back(model_request(r, clear));
    endtask

    task automatic load_all(input logic [mem_pkg::WORD_W-1:0] base);
        send_req(mem_pkg::LW, base, '0, 1'b0);
        for (int off = 0; off < 4; off++) begin
            if (off % 2 == 0) begin
                send_req(mem_pkg::LH, base + off, '0, 1'b0);
                send_req(mem_pkg::LHU, base + off, '0, 1'b0);
            end
            send_req(mem_pkg::LB, base + off, '0, 1'b0);
            send_req(mem_pkg::LBU, base + off, '0, 1'b0);
        end
    endtask

    task automatic drain();
        @(posedge clk);
        #2;
        req         = '0;
        fault_clear = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        #2;
    endtask

    // Outputs sampled mid-cycle
    always @(negedge clk) begin
        mem_pkg::mem_result_t expected;
        if (req_credit) begin
            req_credits++;
        end
        if (res_valid) begin
            if (wb_credits == 0) begin
                errors++;
                $display("res_valid was raised with no write-back credit left");
            end else begin
                wb_credits--;
            end
            pending_returns++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("A result arrived with no request outstanding");
            end else begin
                expected = exp_q.pop_front();
                check_result(res, expected);
            end
        end
        if (res_credit) begin
            wb_credits++;                           // Usable by the DUT from next cycle
        end
    end

    // Write-back side hands credits back one per cycle
    always @(posedge clk) begin
        #2;
        res_credit = 1'b0;
        if (rst_n && !withhold && pending_returns > 0) begin
            if (!random_hold || ($unsigned($random(seed)) % 2) == 0) begin
                res_credit = 1'b1;
                pending_returns--;
            end
        end
    end

    initial begin
        #(NUM_REQS * 20 * 20 + 1000);
        $display("Timeout with %0d results still outstanding", exp_q.size());
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        mem_pkg::mem_op_e           op;
        logic [mem_pkg::WORD_W-1:0] addr;
        int                         n;
        for (int i = 0; i < mem_pkg::DMEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        rst_n       = 1'b0;
        req         = '0;
        res_credit  = 1'b0;
        fault_clear = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_fault(fault_count, fault_addr, fault_sticky);
        // Sub-word stores at every legal offset over a known word
        for (int k = 0; k < 6; k++) begin
            send_req(mem_pkg::SW, 32'h40, 32'h8796_A5B4, 1'b0);
            if (k < 2) begin
                send_req(mem_pkg::SH, 32'h40 + 32'(2 * k), $random(seed), 1'b0);
            end else begin
                send_req(mem_pkg::SB, 32'h40 + 32'(k - 2), $random(seed), 1'b0);
            end
            load_all(32'h40);
        end
        repeat (4) send_req(mem_pkg::NOP, $random(seed), $random(seed), 1'b0);
        drain();
        check_fault(fault_count, fault_addr, fault_sticky);
        for (int off = 1; off < 4; off++) begin
            // Flag cleared first so only the misalignment can hold off the store
            send_req(mem_pkg::NOP, 32'h0, '0, 1'b1);
            send_req(mem_pkg::SW, 32'h40 + off, $random(seed), 1'b0);
            if (off != 2) begin
                send_req(mem_pkg::NOP, 32'h0, '0, 1'b1);
                send_req(mem_pkg::SH, 32'h40 + off, $random(seed), 1'b0);
                send_req(mem_pkg::LH, 32'h40 + off, '0, 1'b0);
                send_req(mem_pkg::LHU, 32'h40 + off, '0, 1'b0);
            end
            send_req(mem_pkg::LW, 32'h40 + off, '0, 1'b0);
        end
        load_all(32'h40);                           // Word must be untouched
        drain();
        check_fault(fault_count, fault_addr, fault_sticky);
        // Sticky flag now set, so stores are held off until the clear
        send_req(mem_pkg::SW, 32'h50, 32'hCAFE_0001, 1'b0);
        send_req(mem_pkg::SB, 32'h51, 32'h0000_00EE, 1'b0);
        send_req(mem_pkg::LW, 32'h50, '0, 1'b0);
        send_req(mem_pkg::NOP, 32'h0, '0, 1'b1);
        send_req(mem_pkg::SW, 32'h50, 32'hCAFE_0002, 1'b0);
        send_req(mem_pkg::LW, 32'h50, '0, 1'b0);
        drain();
        check_fault(fault_count, fault_addr, fault_sticky);
        // Back-pressure with tagged pass-through values
        withhold = 1'b1;
        n        = 0;
        while (req_credits > 0) begin
            send_req(mem_pkg::NOP, 32'h100 + n, '0, 1'b0);
            n++;
        end
        @(posedge clk);
        #2;
        req = '0;
        repeat (20) @(posedge clk);
        if (req_credits != 0) begin
            errors++;
            $display("Request credits returned while write-back was stalled");
        end
        withhold = 1'b0;
        drain();
        random_hold = 1'b1;
        repeat (NUM_RANDOM) begin
            op   = mem_pkg::mem_op_e'(4'($unsigned($random(seed)) % 9));
            addr = $random(seed) & 32'hFFFF_FC3F;   // Sixteen words, any offset
            send_req(op, addr, $random(seed), ($unsigned($random(seed)) % 16) == 0);
        end
        drain();
        check_fault(fault_count, fault_addr, fault_sticky);
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+bench
verilog/mem_pkg.sv
verilog/dmem.sv
verilog/mem_ctrl.sv
verilog/mem_fault_regs.sv
verilog/mem_out_queue.sv
verilog/mem_stage.sv
bench/tb_mem_stage.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the memory stage testbench with Verilator
verilator --binary --timing -f sources.f --top-module tb_mem_stage -o tb_sim \
    && ./obj_dir/tb_sim > sim.log \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "Result: FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "No pass message found"; exit 1; }
exit 0
